/* sources.f */
+incdir+verif
src/hci_cfg_pkg.sv
src/axi_lite_pkg.sv
src/axi_lite_slave.sv
src/hci_queue.sv
src/hci_csr.sv
src/hci_top.sv
verif/hci_checker.sv
verif/tb_hci_top.sv

/* src/axi_lite_pkg.sv */
// AXI4-Lite and CSR bus types
`default_nettype none

package axi_lite_pkg;

  localparam int unsigned AxilAddrWidth = 12;
  localparam int unsigned AxilDataWidth = 32;

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlvErr = 2'b10;

  // Master to slave
  typedef struct packed {
    logic [AxilAddrWidth-1:0]   awaddr;
    logic                       awvalid;
    logic [AxilDataWidth-1:0]   wdata;
    logic [AxilDataWidth/8-1:0] wstrb;
    logic                       wvalid;
    logic                       bready;
    logic [AxilAddrWidth-1:0]   araddr;
    logic                       arvalid;
    logic                       rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                     awready;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     arready;
    logic [AxilDataWidth-1:0] rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [AxilAddrWidth-1:0]   addr;
    logic [AxilDataWidth-1:0]   wdata;
    logic [AxilDataWidth/8-1:0] wstrb;
  } csr_req_t;

  typedef struct packed {
    logic [AxilDataWidth-1:0] rdata;
    logic                     err;
  } csr_rsp_t;

endpackage

`default_nettype wire

/* src/axi_lite_slave.sv */
// AXI4-Lite slave front end
`timescale 1ns/1ps
`default_nettype none

module axi_lite_slave (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  axi_lite_pkg::axil_req_t axil_req_i,
  output axi_lite_pkg::axil_rsp_t axil_rsp_o,
  output axi_lite_pkg::csr_req_t  csr_req_o,
  input  axi_lite_pkg::csr_rsp_t  csr_rsp_i
);
  import axi_lite_pkg::*;

  logic                     wr_accept;
  logic                     rd_accept;
  logic                     bvalid_q;
  logic [1:0]               bresp_q;
  logic                     rvalid_q;
  logic [1:0]               rresp_q;
  logic [AxilDataWidth-1:0] rdata_q;

  // AW and W taken together, write wins over a concurrent read
  assign wr_accept = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
  assign rd_accept = axil_req_i.arvalid && !rvalid_q && !wr_accept;

  always_comb begin
    axil_rsp_o.awready = wr_accept;
    axil_rsp_o.wready  = wr_accept;
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.bvalid  = bvalid_q;
    axil_rsp_o.arready = !rvalid_q && !wr_accept;
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
    axil_rsp_o.rvalid  = rvalid_q;
  end

  // Single-cycle request toward the register block
  always_comb begin
    csr_req_o.valid = wr_accept || rd_accept;
    csr_req_o.write = wr_accept;
    csr_req_o.addr  = wr_accept ? axil_req_i.awaddr : axil_req_i.araddr;
    csr_req_o.wdata = axil_req_i.wdata;
    csr_req_o.wstrb = axil_req_i.wstrb;
  end

  // B channel
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      bresp_q  <= RespOkay;
    end else if (wr_accept) begin
      bvalid_q <= 1'b1;
      bresp_q  <= csr_rsp_i.err ? RespSlvErr : RespOkay;
    end else if (axil_req_i.bready) begin
      bvalid_q <= 1'b0;
    end
  end

  // R channel control
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      rresp_q  <= RespOkay;
    end else if (rd_accept) begin
      rvalid_q <= 1'b1;
      rresp_q  <= csr_rsp_i.err ? RespSlvErr : RespOkay;
    end else if (axil_req_i.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_accept) begin
      rdata_q <= csr_rsp_i.rdata;
    end
  end

  bvalid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_q && !axil_req_i.bready |=> bvalid_q && $stable(bresp_q));

  rvalid_hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_q && !axil_req_i.rready |=> rvalid_q && $stable(rresp_q) && $stable(rdata_q));

endmodule

`default_nettype wire

/* src/hci_cfg_pkg.sv */
// HCI queue configuration
`default_nettype none

package hci_cfg_pkg;

  // Queue geometry
  localparam int unsigned HciQueueDepth = 8;
  localparam int unsigned HciLevelWidth = 4;
  localparam int unsigned HciPtrWidth   = $clog2(HciQueueDepth);

  typedef logic [7:0] thld_t;

  // Threshold value after reset
  localparam thld_t ThldDefault = 8'd1;

  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } cmd_desc_t;

  typedef logic [31:0] resp_desc_t;

  typedef struct packed {
    logic                     empty;
    logic                     full;
    logic                     thld_trig;
    logic [HciLevelWidth-1:0] level;
  } queue_status_t;

  // Register map, byte addresses
  localparam logic [11:0] CmdQueuePortAddr  = 12'h010;
  localparam logic [11:0] RespQueuePortAddr = 12'h014;
  localparam logic [11:0] QueueThldCtrlAddr = 12'h018;
  localparam logic [11:0] QueueStatusAddr   = 12'h01C;
  localparam logic [11:0] ResetControlAddr  = 12'h020;

  // RESET_CONTROL flush bits
  localparam int unsigned CmdQueueRstBit  = 1;
  localparam int unsigned RespQueueRstBit = 2;

endpackage

`default_nettype wire

/* src/hci_csr.sv */
// HCI queue register block
`timescale 1ns/1ps
`default_nettype none

module hci_csr (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  axi_lite_pkg::csr_req_t     csr_req_i,
  output axi_lite_pkg::csr_rsp_t     csr_rsp_o,

  // Command queue
  output logic                       cmd_wvalid_o,
  input  logic                       cmd_wready_i,
  output hci_cfg_pkg::cmd_desc_t     cmd_wdata_o,
  input  hci_cfg_pkg::queue_status_t cmd_status_i,
  output hci_cfg_pkg::thld_t         cmd_thld_o,
  output logic                       cmd_flush_o,

  // Response queue
  input  logic                       resp_rvalid_i,
  output logic                       resp_rready_o,
  input  hci_cfg_pkg::resp_desc_t    resp_rdata_i,
  input  hci_cfg_pkg::queue_status_t resp_status_i,
  output hci_cfg_pkg::thld_t         resp_thld_o,
  output logic                       resp_flush_o
);
  import hci_cfg_pkg::*;
  import axi_lite_pkg::*;

  logic                     wr_req;
  logic                     cmd_port_wr;
  logic                     thld_wr;
  logic                     rst_wr;
  logic                     lo_pending_q;
  logic [31:0]              lo_word_q;
  thld_t                    cmd_thld_q;
  thld_t                    resp_thld_q;

  assign wr_req      = csr_req_i.valid && csr_req_i.write;
  assign cmd_port_wr = wr_req && (csr_req_i.addr == CmdQueuePortAddr);
  assign thld_wr     = wr_req && (csr_req_i.addr == QueueThldCtrlAddr);
  assign rst_wr      = wr_req && (csr_req_i.addr == ResetControlAddr) && csr_req_i.wstrb[0];

  assign cmd_flush_o  = rst_wr && csr_req_i.wdata[CmdQueueRstBit];
  assign resp_flush_o = rst_wr && csr_req_i.wdata[RespQueueRstBit];

  // Second port word completes the descriptor
  assign cmd_wvalid_o = cmd_port_wr && lo_pending_q && !cmd_status_i.full;
  assign cmd_wdata_o  = '{hi: csr_req_i.wdata, lo: lo_word_q};

  assign cmd_thld_o  = cmd_thld_q;
  assign resp_thld_o = resp_thld_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lo_pending_q <= 1'b0;
    end else if (cmd_flush_o) begin
      lo_pending_q <= 1'b0;
    end else if (cmd_port_wr && !cmd_status_i.full) begin
      lo_pending_q <= !lo_pending_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd_port_wr && !lo_pending_q && !cmd_status_i.full) begin
      lo_word_q <= csr_req_i.wdata;
    end
  end

  // Thresholds, one byte lane each
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cmd_thld_q  <= ThldDefault;
      resp_thld_q <= ThldDefault;
    end else if (thld_wr) begin
      if (csr_req_i.wstrb[0]) begin
        cmd_thld_q <= csr_req_i.wdata[7:0];
      end
      if (csr_req_i.wstrb[1]) begin
        resp_thld_q <= csr_req_i.wdata[15:8];
      end
    end
  end

  // Response data and error flag
  always_comb begin
    csr_rsp_o.rdata = '0;
    csr_rsp_o.err   = 1'b0;
    resp_rready_o   = 1'b0;
    if (csr_req_i.valid) begin
      if (csr_req_i.write) begin
        case (csr_req_i.addr)
          CmdQueuePortAddr:  csr_rsp_o.err = !cmd_wready_i;
          QueueThldCtrlAddr: csr_rsp_o.err = 1'b0;
          ResetControlAddr:  csr_rsp_o.err = 1'b0;
          default:           csr_rsp_o.err = 1'b1;
        endcase
      end else begin
        case (csr_req_i.addr)
          RespQueuePortAddr: begin
            // Pop the head in the accept cycle
            if (resp_rvalid_i) begin
              csr_rsp_o.rdata = resp_rdata_i;
              resp_rready_o   = 1'b1;
            end else begin
              csr_rsp_o.err = 1'b1;
            end
          end
          QueueThldCtrlAddr: csr_rsp_o.rdata = {16'b0, resp_thld_q, cmd_thld_q};
          QueueStatusAddr:   csr_rsp_o.rdata = {17'b0, resp_status_i, 1'b0, cmd_status_i};
          default:           csr_rsp_o.err = 1'b1;
        endcase
      end
    end
  end

  // Full flag and queue ready must agree
  cmd_push_ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cmd_wvalid_o |-> cmd_wready_i);

endmodule

`default_nettype wire

/* src/hci_queue.sv */
// HCI queue with ready threshold
`timescale 1ns/1ps
`default_nettype none

module hci_queue #(
  parameter type payload_t = logic [31:0]
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  payload_t                   wdata_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output payload_t                   rdata_o,
  input  hci_cfg_pkg::thld_t         ready_thld_i,
  output hci_cfg_pkg::queue_status_t status_o
);
  import hci_cfg_pkg::*;

  payload_t                 mem [HciQueueDepth];
  logic [HciPtrWidth-1:0]   wptr_q;
  logic [HciPtrWidth-1:0]   rptr_q;
  logic [HciLevelWidth-1:0] level_q;
  logic                     push;
  logic                     pop;
  thld_t                    eff_thld;

  assign push = wvalid_i && wready_o;
  assign pop  = rvalid_o && rready_i;

  // Zero threshold behaves as one
  assign eff_thld = (ready_thld_i == '0) ? thld_t'(1) : ready_thld_i;

  always_comb begin
    status_o.empty     = (level_q == '0);
    status_o.full      = (level_q == HciLevelWidth'(HciQueueDepth));
    status_o.thld_trig = (thld_t'(level_q) >= eff_thld);
    status_o.level     = level_q;
  end

  assign wready_o = !status_o.full;
  assign rvalid_o = !status_o.empty;
  assign rdata_o  = mem[rptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else if (flush_i) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      level_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      // Simultaneous push and pop keep the level
      case ({push, pop})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wptr_q] <= wdata_i;
    end
  end

  level_bound_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    level_q <= HciLevelWidth'(HciQueueDepth));

  // A pop needs stored data behind the pointers
  no_underflow_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop |-> status_o.full || (wptr_q != rptr_q));

endmodule

`default_nettype wire

/* src/hci_top.sv */
// HCI queue block top level
`timescale 1ns/1ps
`default_nettype none

module hci_top (
  input  logic                       aclk_i,
  input  logic                       rst_n_i,
  input  axi_lite_pkg::axil_req_t    s_axil_req_i,
  output axi_lite_pkg::axil_rsp_t    s_axil_rsp_o,
  output logic                       hci_cmd_rvalid_o,
  input  logic                       hci_cmd_rready_i,
  output hci_cfg_pkg::cmd_desc_t     hci_cmd_rdata_o,
  input  logic                       hci_resp_wvalid_i,
  output logic                       hci_resp_wready_o,
  input  hci_cfg_pkg::resp_desc_t    hci_resp_wdata_i,
  output hci_cfg_pkg::queue_status_t hci_cmd_status_o,
  output hci_cfg_pkg::queue_status_t hci_resp_status_o,
  output hci_cfg_pkg::thld_t         hci_cmd_thld_o,
  output hci_cfg_pkg::thld_t         hci_resp_thld_o
);
  import hci_cfg_pkg::*;
  import axi_lite_pkg::*;

  csr_req_t   csr_req;
  csr_rsp_t   csr_rsp;
  logic       cmd_wvalid;
  logic       cmd_wready;
  cmd_desc_t  cmd_wdata;
  logic       cmd_flush;
  logic       resp_rvalid;
  logic       resp_rready;
  resp_desc_t resp_rdata;
  logic       resp_flush;

  axi_lite_slave u_axil_slave (
    .clk_i      (aclk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (s_axil_req_i),
    .axil_rsp_o (s_axil_rsp_o),
    .csr_req_o  (csr_req),
    .csr_rsp_i  (csr_rsp)
  );

  hci_csr u_csr (
    .clk_i         (aclk_i),
    .rst_n_i       (rst_n_i),
    .csr_req_i     (csr_req),
    .csr_rsp_o     (csr_rsp),
    .cmd_wvalid_o  (cmd_wvalid),
    .cmd_wready_i  (cmd_wready),
    .cmd_wdata_o   (cmd_wdata),
    .cmd_status_i  (hci_cmd_status_o),
    .cmd_thld_o    (hci_cmd_thld_o),
    .cmd_flush_o   (cmd_flush),
    .resp_rvalid_i (resp_rvalid),
    .resp_rready_o (resp_rready),
    .resp_rdata_i  (resp_rdata),
    .resp_status_i (hci_resp_status_o),
    .resp_thld_o   (hci_resp_thld_o),
    .resp_flush_o  (resp_flush)
  );

  // Software writes, controller reads
  hci_queue #(
    .payload_t (cmd_desc_t)
  ) u_cmd_queue (
    .clk_i        (aclk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (cmd_flush),
    .wvalid_i     (cmd_wvalid),
    .wready_o     (cmd_wready),
    .wdata_i      (cmd_wdata),
    .rvalid_o     (hci_cmd_rvalid_o),
    .rready_i     (hci_cmd_rready_i),
    .rdata_o      (hci_cmd_rdata_o),
    .ready_thld_i (hci_cmd_thld_o),
    .status_o     (hci_cmd_status_o)
  );

  // Controller writes, software reads
  hci_queue #(
    .payload_t (resp_desc_t)
  ) u_resp_queue (
    .clk_i        (aclk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (resp_flush),
    .wvalid_i     (hci_resp_wvalid_i),
    .wready_o     (hci_resp_wready_o),
    .wdata_i      (hci_resp_wdata_i),
    .rvalid_o     (resp_rvalid),
    .rready_i     (resp_rready),
    .rdata_o      (resp_rdata),
    .ready_thld_i (hci_resp_thld_o),
    .status_o     (hci_resp_status_o)
  );

endmodule

`default_nettype wire

/* verif/hci_tb_types.svh */
// Testbench record types
`ifndef HCI_TB_TYPES_SVH
`define HCI_TB_TYPES_SVH

// One line of the test data file
typedef struct packed {
  logic [15:0] seq;
  logic [7:0]  id;
  logic [2:0]  op;
  logic [11:0] addr;
  logic [31:0] d0;
  logic [31:0] d1;
  logic [31:0] exp_data;
  logic [1:0]  exp_resp;
} test_rec_t;

localparam logic [2:0] OpWrite  = 3'd0;
localparam logic [2:0] OpRead   = 3'd1;
localparam logic [2:0] OpPush   = 3'd2;
localparam logic [2:0] OpPop    = 3'd3;
localparam logic [2:0] OpStatus = 3'd4;

`endif

/* verif/hci_checker.sv */
// HCI queue block response checker
`timescale 1ns/1ps
`default_nettype none
`include "hci_tb_types.svh"

module hci_checker (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  test_rec_t                  rec_i,
  input  axi_lite_pkg::axil_req_t    axil_req_i,
  input  axi_lite_pkg::axil_rsp_t    axil_rsp_i,
  input  logic                       cmd_rvalid_i,
  input  logic                       cmd_rready_i,
  input  hci_cfg_pkg::cmd_desc_t     cmd_rdata_i,
  input  logic                       resp_wvalid_i,
  input  logic                       resp_wready_i,
  input  hci_cfg_pkg::queue_status_t cmd_status_i,
  input  hci_cfg_pkg::queue_status_t resp_status_i,
  input  hci_cfg_pkg::thld_t         cmd_thld_i,
  input  hci_cfg_pkg::thld_t         resp_thld_i,
  output int                         pass_cnt_o,
  output int                         fail_cnt_o
);
  import axi_lite_pkg::*;
  import hci_cfg_pkg::*;

  logic [15:0] done_seq;
  logic        b_held;
  logic        r_held;
  logic        push_taken;
  axil_rsp_t   prev_rsp;
  logic [31:0] status_word;

  // Same layout as the status column of the data file
  assign status_word = {resp_thld_i, cmd_thld_i, resp_wready_i, resp_status_i,
                        1'b0, cmd_status_i};

  task automatic finish_test(input logic ok, input string what,
                             input logic [63:0] got, input logic [63:0] want);
    if (ok) begin
      pass_cnt_o++;
      $display("Test %0d.%0d passed", rec_i.id, rec_i.seq);
    end else begin
      fail_cnt_o++;
      $display("Fail at %0t: test %0d.%0d %s is %h, expected %h", $time, rec_i.id,
               rec_i.seq, what, got, want);
    end
    done_seq = rec_i.seq;
  endtask

  initial begin
    pass_cnt_o = 0;
    fail_cnt_o = 0;
    done_seq   = '0;
    b_held     = 1'b0;
    r_held     = 1'b0;
    push_taken = 1'b0;
  end

  // Inputs settle after the drive delay, so the falling edge sees the next handshake
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      if (b_held && !(axil_rsp_i.bvalid && axil_rsp_i.bresp == prev_rsp.bresp)) begin
        fail_cnt_o++;
        $display("Fail at %0t: write response changed while waiting for bready", $time);
      end
      if (r_held && !(axil_rsp_i.rvalid && axil_rsp_i.rresp == prev_rsp.rresp &&
                      axil_rsp_i.rdata == prev_rsp.rdata)) begin
        fail_cnt_o++;
        $display("Fail at %0t: read response changed while waiting for rready", $time);
      end
      b_held   = axil_rsp_i.bvalid && !axil_req_i.bready;
      r_held   = axil_rsp_i.rvalid && !axil_req_i.rready;
      prev_rsp = axil_rsp_i;
      if (rec_i.seq != done_seq) begin
        case (rec_i.op)
          OpWrite: if (axil_rsp_i.bvalid && axil_req_i.bready) begin
            finish_test(axil_rsp_i.bresp == rec_i.exp_resp, "bresp",
                        64'(axil_rsp_i.bresp), 64'(rec_i.exp_resp));
          end
          OpRead: if (axil_rsp_i.rvalid && axil_req_i.rready) begin
            finish_test(axil_rsp_i.rdata == rec_i.exp_data &&
                        axil_rsp_i.rresp == rec_i.exp_resp, "{rresp, rdata}",
                        {30'b0, axil_rsp_i.rresp, axil_rsp_i.rdata},
                        {30'b0, rec_i.exp_resp, rec_i.exp_data});
          end
          // A pushed response shows in the status one clock later
          OpPush: if (push_taken) begin
            push_taken = 1'b0;
            finish_test(!resp_status_i.empty, "response queue empty",
                        64'(resp_status_i.empty), 64'd0);
          end else if (resp_wvalid_i && resp_wready_i) begin
            push_taken = 1'b1;
          end
          OpPop: if (cmd_rvalid_i && cmd_rready_i) begin
            finish_test(cmd_rdata_i == {rec_i.d0, rec_i.d1}, "command",
                        cmd_rdata_i, {rec_i.d0, rec_i.d1});
          end
          OpStatus: begin
            finish_test(status_word == rec_i.exp_data, "status",
                        64'(status_word), 64'(rec_i.exp_data));
          end
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* verif/hci_testdata.txt */
# id op addr d0 d1 expected resp
# op 0 write (d0 data, d1 strobes), 1 read, 2 response push (d0), 3 command pop ({d0,d1}), 4 status
1 0 010 aaaa0001 f 0 0
1 0 010 bbbb0001 f 0 0
1 0 010 aaaa0002 f 0 0
1 0 010 bbbb0002 f 0 0
1 4 000 0 0 0101c012 0
1 3 000 bbbb0001 aaaa0001 0 0
1 3 000 bbbb0002 aaaa0002 0 0
2 2 000 c0de0001 0 0 0
2 2 000 c0de0002 0 0 0
2 1 014 0 0 c0de0001 0
2 1 014 0 0 c0de0002 0
2 1 014 0 0 0 2
3 0 018 00000302 f 0 0
3 1 018 0 0 00000302 0
3 0 010 11110001 f 0 0
3 0 010 22220001 f 0 0
3 2 000 d0d00001 0 0 0
3 1 01c 0 0 00000101 0
3 0 010 11110002 f 0 0
3 0 010 22220002 f 0 0
3 4 000 0 0 03028112 0
4 0 010 11110003 f 0 0
4 0 010 22220003 f 0 0
4 0 010 11110004 f 0 0
4 0 010 22220004 f 0 0
4 0 010 11110005 f 0 0
4 0 010 22220005 f 0 0
4 0 010 11110006 f 0 0
4 0 010 22220006 f 0 0
4 0 010 11110007 f 0 0
4 0 010 22220007 f 0 0
4 0 010 11110008 f 0 0
4 0 010 22220008 f 0 0
4 0 010 99999999 f 0 2
4 4 000 0 0 03028138 0
4 3 000 22220001 11110001 0 0
4 0 010 33330009 f 0 0
4 4 000 0 0 03028117 0
4 2 000 e0e00001 0 0 0
4 2 000 e0e00002 0 0 0
4 2 000 e0e00003 0 0 0
4 2 000 e0e00004 0 0 0
4 2 000 e0e00005 0 0 0
4 2 000 e0e00006 0 0 0
4 2 000 e0e00007 0 0 0
4 4 000 0 0 03023817 0
5 0 020 00000006 f 0 0
5 4 000 0 0 0302c040 0
5 1 01c 0 0 00004040 0
5 1 030 0 0 0 2
5 0 024 12345678 f 0 2
5 0 010 55550001 f 0 0
5 0 010 66660001 f 0 0
5 3 000 66660001 55550001 0 0
6 2 000 f00d0001 0 0 0
6 2 000 f00d0002 0 0 0
6 1 014 0 0 f00d0001 0
6 1 014 0 0 f00d0002 0

/* verif/tb_hci_top.sv */
// HCI queue block testbench
`timescale 1ns/1ps
`default_nettype none
`include "hci_tb_types.svh"

module tb_hci_top;
  import axi_lite_pkg::*;
  import hci_cfg_pkg::*;

  localparam int ClkPeriod  = 40;
  localparam int DriveDelay = 2;

  logic          aclk;
  logic          rst_n;
  axil_req_t     axil_req;
  axil_rsp_t     axil_rsp;
  logic          cmd_rvalid;
  logic          cmd_rready;
  cmd_desc_t     cmd_rdata;
  logic          resp_wvalid;
  logic          resp_wready;
  resp_desc_t    resp_wdata;
  queue_status_t cmd_status;
  queue_status_t resp_status;
  thld_t         cmd_thld;
  thld_t         resp_thld;
  test_rec_t     rec;
  test_rec_t     tests[$];
  int            pass_cnt;
  int            fail_cnt;
  int            cycles = 0;
  int            cycle_limit = 0;
  integer        seed;
  logic          load_ok;

  hci_top DUT (
    .aclk_i            (aclk),
    .rst_n_i           (rst_n),
    .s_axil_req_i      (axil_req),
    .s_axil_rsp_o      (axil_rsp),
    .hci_cmd_rvalid_o  (cmd_rvalid),
    .hci_cmd_rready_i  (cmd_rready),
    .hci_cmd_rdata_o   (cmd_rdata),
    .hci_resp_wvalid_i (resp_wvalid),
    .hci_resp_wready_o (resp_wready),
    .hci_resp_wdata_i  (resp_wdata),
    .hci_cmd_status_o  (cmd_status),
    .hci_resp_status_o (resp_status),
    .hci_cmd_thld_o    (cmd_thld),
    .hci_resp_thld_o   (resp_thld)
  );

  hci_checker u_checker (
    .clk_i         (aclk),
    .rst_n_i       (rst_n),
    .rec_i         (rec),
    .axil_req_i    (axil_req),
    .axil_rsp_i    (axil_rsp),
    .cmd_rvalid_i  (cmd_rvalid),
    .cmd_rready_i  (cmd_rready),
    .cmd_rdata_i   (cmd_rdata),
    .resp_wvalid_i (resp_wvalid),
    .resp_wready_i (resp_wready),
    .cmd_status_i  (cmd_status),
    .resp_status_i (resp_status),
    .cmd_thld_i    (cmd_thld),
    .resp_thld_i   (resp_thld),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  initial begin
    aclk = 1'b0;
    forever #(ClkPeriod / 2) aclk = ~aclk;
  end

  always @(posedge aclk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout: test %0d.%0d saw no handshake within %0d cycles", rec.id, rec.seq,
               cycle_limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic load_tests(output logic ok);
    int          fd;
    int          code;
    string       line;
    int          id;
    int          op;
    int          resp;
    logic [31:0] addr;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] exp_data;
    test_rec_t   t;
    fd = $fopen("verif/hci_testdata.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line[0] != "#") begin
          code = $sscanf(line, "%d %d %h %h %h %h %d", id, op, addr, d0, d1, exp_data, resp);
          if (code == 7) begin
            t.seq      = 16'(tests.size() + 1);
            t.id       = 8'(id);
            t.op       = 3'(op);
            t.addr     = addr[11:0];
            t.d0       = d0;
            t.d1       = d1;
            t.exp_data = exp_data;
            t.exp_resp = 2'(resp);
            tests.push_back(t);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic next_cycle();
    @(posedge aclk);
    #DriveDelay;
  endtask

  // Hold bready or rready low for a few extra cycles
  task automatic random_stall();
    int n;
    n = $random(seed) & 3;
    repeat (n) next_cycle();
  endtask

  task automatic axi_write(input test_rec_t t);
    axil_req.awaddr  = t.addr;
    axil_req.wdata   = t.d0;
    axil_req.wstrb   = t.d1[3:0];
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    @(negedge aclk);
    while (!axil_rsp.awready) @(negedge aclk);
    next_cycle();
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    random_stall();
    axil_req.bready = 1'b1;
    @(negedge aclk);
    while (!axil_rsp.bvalid) @(negedge aclk);
    next_cycle();
    axil_req.bready = 1'b0;
  endtask

  task automatic axi_read(input test_rec_t t);
    axil_req.araddr  = t.addr;
    axil_req.arvalid = 1'b1;
    @(negedge aclk);
    while (!axil_rsp.arready) @(negedge aclk);
    next_cycle();
    axil_req.arvalid = 1'b0;
    random_stall();
    axil_req.rready = 1'b1;
    @(negedge aclk);
    while (!axil_rsp.rvalid) @(negedge aclk);
    next_cycle();
    axil_req.rready = 1'b0;
  endtask

  task automatic run_test(input test_rec_t t);
    rec = t;
    case (t.op)
      OpWrite: axi_write(t);
      OpRead:  axi_read(t);
      OpPush: begin
        resp_wdata  = t.d0;
        resp_wvalid = 1'b1;
        @(negedge aclk);
        while (!resp_wready) @(negedge aclk);
        next_cycle();
        resp_wvalid = 1'b0;
        // Status of the pushed entry is sampled in this cycle
        next_cycle();
      end
      OpPop: begin
        cmd_rready = 1'b1;
        @(negedge aclk);
        while (!cmd_rvalid) @(negedge aclk);
        next_cycle();
        cmd_rready = 1'b0;
      end
      default: next_cycle();
    endcase
  endtask

  initial begin
    seed        = 32'h32d3;
    axil_req    = '0;
    cmd_rready  = 1'b0;
    resp_wvalid = 1'b0;
    resp_wdata  = '0;
    rec         = '0;
    rst_n       = 1'b0;
    load_tests(load_ok);
    if (!load_ok) begin
      $display("Could not open verif/hci_testdata.txt");
      $display("** FAIL **");
      $finish;
    end else begin
      cycle_limit = tests.size() * 20 + 100;
      repeat (3) @(posedge aclk);
      #DriveDelay;
      rst_n = 1'b1;
      next_cycle();
      foreach (tests[i]) run_test(tests[i]);
      next_cycle();
      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && pass_cnt == tests.size()) begin
        $display("** PASS **");
      end else begin
        if (pass_cnt + fail_cnt != tests.size()) begin
          $display("Only %0d of %0d tests were checked", pass_cnt + fail_cnt, tests.size());
        end
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
